// ==== addr_pkg.sv ====
package addr_pkg;

  // Virtual and physical addresses are the same width here
  localparam int VADDR_W = 32;
  localparam int PADDR_W = 32;

  // 4 KB pages
  localparam int PAGE_OFF_W = 12;

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;

  // Page numbers are the address bits above the page offset
  typedef logic [VADDR_W-PAGE_OFF_W-1:0] vpn_t;
  typedef logic [PADDR_W-PAGE_OFF_W-1:0] ppn_t;

endpackage

// ==== fetch_asserts.sv ====
`timescale 1ns/10ps

module fetch_asserts import addr_pkg::*; (
  input logic clk,
  input logic reset,
  input logic enable,
  input logic branch_taken,
  input logic syscall_flush,
  input logic instr_valid,
  input logic tlb_miss,
  input logic line_miss,
  input paddr_t miss_paddr
);

  // Only one refill is outstanding at a time
  miss_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(tlb_miss && line_miss))
    else $error("tlb_miss and line_miss are high together");

  paddr_stable: assert property (@(posedge clk) disable iff (reset)
    line_miss && $past(line_miss) |-> $stable(miss_paddr))
    else $error("miss_paddr changed while line_miss is high");

  no_fetch_when_blocked: assert property (@(posedge clk) disable iff (reset)
    (!enable || branch_taken || syscall_flush) |=> !instr_valid)
    else $error("instr_valid after a cycle with enable low or a redirect");

  quiet_after_reset: assert property (@(posedge clk) reset |=> !instr_valid)
    else $error("instr_valid high in the cycle after reset");

endmodule

bind fetch_top fetch_asserts u_fetch_asserts (.*);

// ==== fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl import addr_pkg::*, fetch_pkg::*; #(
  parameter int ICACHE_SETS = 16
) (
  input  logic clk,
  input  logic reset,
  input  vaddr_t entry,
  input  logic enable,
  input  logic branch_taken,
  input  vaddr_t branch_target,
  input  logic syscall_flush,
  input  vaddr_t flush_addr,
  input  logic tlb_fill,
  input  ppn_t tlb_fill_ppn,
  input  logic line_fill,
  input  line_t line_fill_data,
  xlate_if.ctrl lookup,
  icache_if.ctrl lines,
  output logic instr_valid,
  output instr_t instr,
  output vaddr_t instr_pc,
  output vaddr_t pc_plus4,
  output logic tlb_miss,
  output vpn_t miss_vpn,
  output logic line_miss,
  output paddr_t miss_paddr
);

  localparam int IDX_W = $clog2(ICACHE_SETS);
  localparam int WORD_W = $clog2(LINE_WORDS);
  // Byte offset inside a line
  localparam int LINE_OFF_W = WORD_W + 2;

  fetch_state_e state;
  vaddr_t pc_q;
  logic redirect;
  vaddr_t redirect_pc;
  logic cache_hit;
  logic fetch;
  logic [WORD_W-1:0] word_sel;
  instr_t fetch_word;

  // Flush wins over branch
  assign redirect = syscall_flush | branch_taken;
  assign redirect_pc = syscall_flush ? flush_addr : branch_target;

  // Both lookups run in parallel on the current PC
  assign lookup.vpn = pc_q[VADDR_W-1:PAGE_OFF_W];
  assign lines.index = pc_q[LINE_OFF_W +: IDX_W];

  assign cache_hit = lookup.hit && lines.tag_valid && (lines.tag == lookup.ppn);
  assign fetch = (state == RUN) && cache_hit && enable && !redirect;

  assign word_sel = pc_q[2 +: WORD_W];
  assign fetch_word = lines.word[word_sel*INSTR_W +: INSTR_W];

  // Refills only count in the wait state they answer
  assign lookup.fill = tlb_fill && (state == TLB_WAIT);
  assign lookup.fill_ppn = tlb_fill_ppn;
  assign lines.fill = line_fill && (state == LINE_WAIT);
  assign lines.fill_tag = lookup.ppn;
  assign lines.fill_line = line_fill_data;

  assign tlb_miss = (state == TLB_WAIT);
  assign miss_vpn = pc_q[VADDR_W-1:PAGE_OFF_W];
  assign line_miss = (state == LINE_WAIT);
  assign miss_paddr = {lookup.ppn, pc_q[PAGE_OFF_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= entry;
      state <= RUN;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= fetch;
      if (redirect) begin
        pc_q <= redirect_pc;
        state <= RUN;
      end else begin
        case (state)
          RUN: begin
            if (!lookup.hit) begin
              state <= TLB_WAIT;
            end else if (!cache_hit) begin
              state <= LINE_WAIT;
            end else if (enable) begin
              pc_q <= pc_q + vaddr_t'(4);
            end
          end
          TLB_WAIT: begin
            if (tlb_fill) begin
              state <= RUN;
            end
          end
          LINE_WAIT: begin
            if (line_fill) begin
              state <= RUN;
            end
          end
          default: state <= RUN;
        endcase
      end
    end
  end

  // Output payload is only meaningful with instr_valid
  always_ff @(posedge clk) begin
    if (fetch) begin
      instr <= fetch_word;
      instr_pc <= pc_q;
      pc_plus4 <= pc_q + vaddr_t'(4);
    end
  end

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

  localparam int INSTR_W = 32;

  typedef logic [INSTR_W-1:0] instr_t;

  // Instructions per cache line
  localparam int LINE_WORDS = 4;

  // Word 0 sits in the low bits
  typedef logic [LINE_WORDS*INSTR_W-1:0] line_t;

  // Fetch control states
  typedef enum logic [1:0] {
    RUN,
    TLB_WAIT,
    LINE_WAIT
  } fetch_state_e;

endpackage

// ==== fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top import addr_pkg::*, fetch_pkg::*; #(
  parameter int TLB_ENTRIES = 4,
  parameter int ICACHE_SETS = 16
) (
  input  logic clk,
  input  logic reset,
  input  vaddr_t entry,
  input  logic enable,
  input  logic branch_taken,
  input  vaddr_t branch_target,
  input  logic syscall_flush,
  input  vaddr_t flush_addr,
  input  logic tlb_fill,
  input  ppn_t tlb_fill_ppn,
  input  logic line_fill,
  input  line_t line_fill_data,
  output logic instr_valid,
  output instr_t instr,
  output vaddr_t instr_pc,
  output vaddr_t pc_plus4,
  output logic tlb_miss,
  output vpn_t miss_vpn,
  output logic line_miss,
  output paddr_t miss_paddr
);

  xlate_if xlate_bus ();
  icache_if #(.ICACHE_SETS(ICACHE_SETS)) cache_bus ();

  itlb #(
    .TLB_ENTRIES(TLB_ENTRIES)
  ) u_itlb (
    .clk    (clk),
    .reset  (reset),
    .lookup (xlate_bus.tlb)
  );

  icache #(
    .ICACHE_SETS(ICACHE_SETS)
  ) u_icache (
    .clk   (clk),
    .reset (reset),
    .lines (cache_bus.cache)
  );

  fetch_ctrl #(
    .ICACHE_SETS(ICACHE_SETS)
  ) u_fetch_ctrl (
    .clk            (clk),
    .reset          (reset),
    .entry          (entry),
    .enable         (enable),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .syscall_flush  (syscall_flush),
    .flush_addr     (flush_addr),
    .tlb_fill       (tlb_fill),
    .tlb_fill_ppn   (tlb_fill_ppn),
    .line_fill      (line_fill),
    .line_fill_data (line_fill_data),
    .lookup         (xlate_bus.ctrl),
    .lines          (cache_bus.ctrl),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_pc       (instr_pc),
    .pc_plus4       (pc_plus4),
    .tlb_miss       (tlb_miss),
    .miss_vpn       (miss_vpn),
    .line_miss      (line_miss),
    .miss_paddr     (miss_paddr)
  );

endmodule

// ==== flist.f ====
addr_pkg.sv
fetch_pkg.sv
xlate_if.sv
icache_if.sv
itlb.sv
icache.sv
fetch_ctrl.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch.sv

// ==== icache.sv ====
`timescale 1ns/10ps

module icache import addr_pkg::*, fetch_pkg::*; #(
  parameter int ICACHE_SETS = 16
) (
  input logic clk,
  input logic reset,
  icache_if.cache lines
);

  localparam int IDX_W = $clog2(ICACHE_SETS);

  logic [ICACHE_SETS-1:0] valid_q;
  ppn_t tag_q [ICACHE_SETS];
  line_t line_q [ICACHE_SETS];

  logic [IDX_W-1:0] set_idx;

  // Index comes straight from the page offset, so no translation is needed
  assign set_idx = lines.index;

  // Combinational read of the indexed set
  assign lines.tag_valid = valid_q[set_idx];
  assign lines.tag = tag_q[set_idx];
  assign lines.word = line_q[set_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (lines.fill) begin
      valid_q[set_idx] <= 1'b1;
    end
  end

  // Each refill of a set overwrites its tag and line
  always_ff @(posedge clk) begin
    if (lines.fill) begin
      tag_q[set_idx] <= lines.fill_tag;
      line_q[set_idx] <= lines.fill_line;
    end
  end

endmodule

// ==== icache_if.sv ====
`timescale 1ns/10ps

interface icache_if import addr_pkg::*, fetch_pkg::*; #(
  parameter int ICACHE_SETS = 16
) ();

  localparam int IDX_W = $clog2(ICACHE_SETS);

  logic [IDX_W-1:0] index;
  logic tag_valid;
  ppn_t tag;
  // Fetch control picks the word out of the whole indexed line
  line_t word;

  logic fill;
  ppn_t fill_tag;
  line_t fill_line;

  modport ctrl (
    output index,
    output fill,
    output fill_tag,
    output fill_line,
    input  tag_valid,
    input  tag,
    input  word
  );

  modport cache (
    input  index,
    input  fill,
    input  fill_tag,
    input  fill_line,
    output tag_valid,
    output tag,
    output word
  );

endinterface

// ==== itlb.sv ====
`timescale 1ns/10ps

module itlb import addr_pkg::*; #(
  parameter int TLB_ENTRIES = 4
) (
  input logic clk,
  input logic reset,
  xlate_if.tlb lookup
);

  localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] valid_q;
  vpn_t vpn_q [TLB_ENTRIES];
  ppn_t ppn_q [TLB_ENTRIES];

  // Next entry to be replaced
  logic [PTR_W-1:0] rr_ptr;

  // At most one entry matches because fills only happen on a miss
  always_comb begin
    lookup.hit = 1'b0;
    lookup.ppn = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (valid_q[i] && (vpn_q[i] == lookup.vpn)) begin
        lookup.hit = 1'b1;
        lookup.ppn = ppn_q[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      rr_ptr <= '0;
    end else if (lookup.fill) begin
      valid_q[rr_ptr] <= 1'b1;
      // Oldest fill is evicted first
      if (rr_ptr == PTR_W'(TLB_ENTRIES - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

  // Translation pairs
  always_ff @(posedge clk) begin
    if (lookup.fill) begin
      vpn_q[rr_ptr] <= lookup.vpn;
      ppn_q[rr_ptr] <= lookup.fill_ppn;
    end
  end

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/10ps

module tb_fetch import addr_pkg::*, fetch_pkg::*;;

  localparam int ROWS = 10;
  localparam int TIMEOUT = 200;
  localparam int ACT_RUN = 0;
  localparam int ACT_BRANCH = 1;
  localparam int ACT_FLUSH = 2;
  localparam ppn_t PT_XOR = 20'h0A5A5;
  localparam instr_t MEM_XOR = 32'hC0DE_0000;

  typedef struct {
    int act;
    vaddr_t addr;
    int count;
    bit gaps;
    int tlb_misses;
    int line_misses;
  } row_t;

  logic clk;
  logic reset;
  vaddr_t entry;
  logic enable;
  logic branch_taken;
  vaddr_t branch_target;
  logic syscall_flush;
  vaddr_t flush_addr;
  logic tlb_fill;
  ppn_t tlb_fill_ppn;
  logic line_fill;
  line_t line_fill_data;
  logic instr_valid;
  instr_t instr;
  vaddr_t instr_pc;
  vaddr_t pc_plus4;
  logic tlb_miss;
  vpn_t miss_vpn;
  logic line_miss;
  paddr_t miss_paddr;

  row_t rows [ROWS];
  vaddr_t next_pc;
  int tlb_rises;
  int line_rises;
  logic tlb_seen = 1'b0;
  logic line_seen = 1'b0;
  int tlb_delay = 0;
  int line_delay = 0;
  int row_errors;
  int total_errors = 0;
  int rows_failed = 0;
  bit timed_out = 1'b0;

  fetch_top #(
    .TLB_ENTRIES(4),
    .ICACHE_SETS(16)
  ) u_fetch_top (.*);

  always #2 clk = ~clk;

  // Page table and memory contents of the system model
  function automatic ppn_t page_entry(input vpn_t vpn);
    return vpn ^ PT_XOR;
  endfunction

  function automatic instr_t model_word(input paddr_t p);
    return p ^ MEM_XOR;
  endfunction

  function automatic paddr_t translate(input vaddr_t v);
    return {page_entry(v[VADDR_W-1:PAGE_OFF_W]), v[PAGE_OFF_W-1:0]};
  endfunction

  function automatic line_t memory_line(input paddr_t base);
    line_t data;
    for (int i = 0; i < LINE_WORDS; i++) begin
      data[i*INSTR_W +: INSTR_W] = model_word(base + paddr_t'(4 * i));
    end
    return data;
  endfunction

  // One refill strobe per miss after a random delay
  always @(negedge clk) begin
    tlb_fill = 1'b0;
    line_fill = 1'b0;
    if (tlb_miss) begin
      if (tlb_delay == 0) begin
        tlb_fill = 1'b1;
        tlb_fill_ppn = page_entry(miss_vpn);
        tlb_delay = $urandom % 6;
      end else begin
        tlb_delay--;
      end
    end
    if (line_miss) begin
      if (line_delay == 0) begin
        line_fill = 1'b1;
        line_fill_data = memory_line(miss_paddr);
        line_delay = $urandom % 6;
      end else begin
        line_delay--;
      end
    end
  end

  task automatic step_cycle();
    @(negedge clk);
    if (tlb_miss && !tlb_seen) begin
      tlb_rises++;
    end
    if (line_miss && !line_seen) begin
      line_rises++;
    end
    tlb_seen = tlb_miss;
    line_seen = line_miss;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      row_errors++;
    end
  endtask

  task automatic run_row(input int r);
    vaddr_t exp_pc;
    int got;
    int idle;
    row_errors = 0;
    tlb_rises = 0;
    line_rises = 0;
    step_cycle();
    exp_pc = next_pc;
    if (rows[r].act != ACT_RUN) begin
      exp_pc = rows[r].addr;
      branch_taken = 1'b1;
      branch_target = rows[r].addr;
      // Branch points elsewhere so that only the flush target is correct
      if (rows[r].act == ACT_FLUSH) begin
        syscall_flush = 1'b1;
        flush_addr = rows[r].addr;
        branch_target = rows[r].addr + vaddr_t'(32'h40);
      end
    end
    enable = 1'b1;
    got = 0;
    idle = 0;
    while (got < rows[r].count && idle < TIMEOUT) begin
      step_cycle();
      branch_taken = 1'b0;
      syscall_flush = 1'b0;
      if (instr_valid) begin
        check_value("instr_pc", exp_pc, instr_pc);
        check_value("pc_plus4", exp_pc + vaddr_t'(4), pc_plus4);
        check_value("instr", model_word(translate(exp_pc)), instr);
        exp_pc = exp_pc + vaddr_t'(4);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
      // A pending miss is always for the next address in the stream
      if (tlb_miss) begin
        check_value("miss_vpn", exp_pc[VADDR_W-1:PAGE_OFF_W], miss_vpn);
      end
      if (line_miss) begin
        check_value("miss_paddr", translate(exp_pc) & ~paddr_t'(4 * LINE_WORDS - 1),
                    miss_paddr);
      end
      enable = rows[r].gaps ? (($urandom % 3) != 0) : 1'b1;
    end
    enable = 1'b0;
    if (got < rows[r].count) begin
      $display("row %0d timed out after %0d cycles without a valid instruction", r, TIMEOUT);
      row_errors++;
      timed_out = 1'b1;
    end
    check_value("tlb_miss rises", rows[r].tlb_misses, tlb_rises);
    check_value("line_miss rises", rows[r].line_misses, line_rises);
    next_pc = exp_pc;
    total_errors += row_errors;
    if (row_errors != 0) begin
      rows_failed++;
    end
    $display("row %0d: %0d of %0d instructions, %0d errors", r, got, rows[r].count, row_errors);
  endtask

  initial begin
    void'($urandom(32645));
    // Action, address, count, gaps, expected tlb_miss and line_miss rises
    rows[0] = '{ACT_RUN, 32'h0000_1FC4, 40, 1'b0, 2, 11};
    rows[1] = '{ACT_RUN, 32'h0, 12, 1'b1, 0, 3};
    rows[2] = '{ACT_BRANCH, 32'h0000_2010, 8, 1'b0, 0, 0};
    rows[3] = '{ACT_FLUSH, 32'h0000_3000, 6, 1'b0, 1, 2};
    rows[4] = '{ACT_BRANCH, 32'h0000_2004, 2, 1'b0, 0, 1};
    rows[5] = '{ACT_BRANCH, 32'h0000_3004, 2, 1'b1, 0, 1};
    rows[6] = '{ACT_BRANCH, 32'h0000_2004, 2, 1'b0, 0, 1};
    rows[7] = '{ACT_BRANCH, 32'h0000_4000, 2, 1'b0, 1, 1};
    rows[8] = '{ACT_BRANCH, 32'h0000_5020, 2, 1'b0, 1, 1};
    rows[9] = '{ACT_BRANCH, 32'h0000_1FE0, 2, 1'b0, 1, 0};
    clk = 1'b0;
    reset = 1'b1;
    entry = rows[0].addr;
    enable = 1'b0;
    branch_taken = 1'b0;
    branch_target = '0;
    syscall_flush = 1'b0;
    flush_addr = '0;
    tlb_fill = 1'b0;
    tlb_fill_ppn = '0;
    line_fill = 1'b0;
    line_fill_data = '0;
    repeat (4) begin
      @(negedge clk);
      if (instr_valid !== 1'b0) begin
        $display("error: instr_valid expected %h actual %h", 1'b0, instr_valid);
        total_errors++;
      end
    end
    reset = 1'b0;
    next_pc = entry;
    for (int r = 0; r < ROWS && !timed_out; r++) begin
      run_row(r);
    end
    $display("rows failed %0d of %0d, errors %0d", rows_failed, ROWS, total_errors);
    if (total_errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== xlate_if.sv ====
`timescale 1ns/10ps

interface xlate_if import addr_pkg::*; ();

  // Lookup of the current fetch page
  vpn_t vpn;
  logic hit;
  ppn_t ppn;

  // Refill of the page at vpn
  logic fill;
  ppn_t fill_ppn;

  modport ctrl (
    output vpn,
    output fill,
    output fill_ppn,
    input  hit,
    input  ppn
  );

  modport tlb (
    input  vpn,
    input  fill,
    input  fill_ppn,
    output hit,
    output ppn
  );

endinterface
